// File: src/axi_mem_pkg.sv
package axi_mem_pkg;

localparam int addr_w = 32;
localparam int data_w = 32;
localparam int id_w   = 11;
localparam int strb_w = data_w / 8;

localparam logic [1:0] burst_fixed = 2'd0;
localparam logic [1:0] burst_incr  = 2'd1;
localparam logic [1:0] burst_wrap  = 2'd2;
localparam logic [1:0] resp_okay   = 2'd0;

localparam int mem_words = 1024;
localparam int mem_aw    = $clog2(mem_words); // Word index taken from addr[mem_aw+1:2].

localparam int refresh_period = 16;
localparam int refresh_w      = $clog2(refresh_period);
localparam logic [refresh_w-1:0] refresh_last = refresh_w'(refresh_period - 1);

typedef struct packed {
    logic [id_w-1:0]   id;
    logic [addr_w-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
} axi_ax_t;

typedef struct packed {
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
    logic              last;
} axi_w_t;

typedef struct packed {
    logic [id_w-1:0] id;
    logic [1:0]      resp;
} axi_b_t;

typedef struct packed {
    logic [id_w-1:0]   id;
    logic [data_w-1:0] data;
    logic [1:0]        resp;
    logic              last;
} axi_r_t;

// One request word on the memory side, strobes and payload together.
typedef struct packed {
    logic              cs;
    logic              we;
    logic [addr_w-1:0] addr;
    logic [strb_w-1:0] byte_en;
    logic [data_w-1:0] wdata;
} mem_req_t;

endpackage

// File: src/axi_burst_addr.sv
`timescale 1ns/1ns

module axi_burst_addr (
    input  logic                             aclk,
    input  logic                             aresetn,
    input  logic                             load,
    input  axi_mem_pkg::axi_ax_t             req,
    input  logic                             step,
    output logic [axi_mem_pkg::addr_w-1:0]   addr
);

logic [axi_mem_pkg::addr_w-1:0] addr_q;
logic [axi_mem_pkg::addr_w-1:0] mask_q;   // Bits that never change during the burst.
logic [axi_mem_pkg::addr_w-1:0] mask_new;
logic [axi_mem_pkg::addr_w-1:0] wrap_bytes;
logic [axi_mem_pkg::addr_w-1:0] beat_bytes;
logic [axi_mem_pkg::addr_w-1:0] addr_inc;
logic [2:0]                     size_q;

// Total bytes covered by a WRAP burst, always a power of two.
assign wrap_bytes = ({{(axi_mem_pkg::addr_w-8){1'b0}}, req.len} + 1'b1) << req.size;
assign beat_bytes = {{(axi_mem_pkg::addr_w-1){1'b0}}, 1'b1} << size_q;
assign addr_inc   = addr_q + beat_bytes;

always_comb begin
    case (req.burst)
        axi_mem_pkg::burst_fixed: begin
            mask_new = '1;
        end
        axi_mem_pkg::burst_wrap: begin
            mask_new = ~(wrap_bytes - 1'b1);
        end
        default: begin
            mask_new = '0; // INCR, and the reserved code behaves the same.
        end
    endcase
end

always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
        addr_q <= '0;
        mask_q <= '0;
        size_q <= 3'd0;
    end
    else begin
        if (load) begin
            addr_q <= req.addr;
            mask_q <= mask_new;
            size_q <= req.size;
        end
        else if (step) begin
            addr_q <= (addr_q & mask_q) | (addr_inc & ~mask_q);
        end
    end
end

assign addr = addr_q;

endmodule

// File: src/axi2mem_bridge.sv
`timescale 1ns/1ns

module axi2mem_bridge (
    input  logic                             aclk,
    input  logic                             aresetn,
    input  axi_mem_pkg::axi_ax_t             aw,
    input  logic                             aw_valid,
    output logic                             aw_ready,
    input  axi_mem_pkg::axi_w_t              w,
    input  logic                             w_valid,
    output logic                             w_ready,
    output axi_mem_pkg::axi_b_t              b,
    output logic                             b_valid,
    input  logic                             b_ready,
    input  axi_mem_pkg::axi_ax_t             ar,
    input  logic                             ar_valid,
    output logic                             ar_ready,
    output axi_mem_pkg::axi_r_t              r,
    output logic                             r_valid,
    input  logic                             r_ready,
    output axi_mem_pkg::mem_req_t            mem_req,
    input  logic [axi_mem_pkg::data_w-1:0]   mem_rdata,
    input  logic                             mem_busy
);

typedef enum logic [1:0] {
    st_idle,
    st_write,
    st_resp,
    st_read
} state_t;

state_t                         state;
state_t                         state_nxt;
axi_mem_pkg::axi_ax_t           req_sel;
logic [axi_mem_pkg::id_w-1:0]   id_q;
logic [7:0]                     cnt;          // Beats left to transfer, minus one.
logic [8:0]                     issue_left;   // Memory reads still to be issued.
logic                           req_take;
logic                           w_beat;
logic                           r_beat;
logic                           rd_issue;
logic                           rd_pend;      // Memory accepted a read on the last edge.
logic                           hold_valid;
logic [axi_mem_pkg::data_w-1:0] hold_q;
logic [axi_mem_pkg::addr_w-1:0] mem_addr;

// A pending read always wins over a pending write.
assign req_sel  = ar_valid ? ar : aw;
assign ar_ready = (state == st_idle);
assign aw_ready = (state == st_idle) & ~ar_valid;
assign req_take = (state == st_idle) & (ar_valid | aw_valid);

assign w_ready = (state == st_write) & ~mem_busy;
assign w_beat  = w_ready & w_valid;
assign b_valid = (state == st_resp);

assign r_valid = rd_pend | hold_valid;
assign r_beat  = r_valid & r_ready;

// Read one beat ahead, but only when the beat on the bus leaves in this cycle.
assign rd_issue = (state == st_read) & (issue_left != 9'd0) & ~mem_busy
                & (~r_valid | r_ready);

axi_burst_addr burst_addr0 (
    .aclk    (aclk),
    .aresetn (aresetn),
    .load    (req_take),
    .req     (req_sel),
    .step    (w_beat | rd_issue),
    .addr    (mem_addr)
);

always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
        state <= st_idle;
    end
    else begin
        state <= state_nxt;
    end
end

always_comb begin
    state_nxt = state;
    case (state)
        st_idle: begin
            if (ar_valid) begin
                state_nxt = st_read;
            end
            else if (aw_valid) begin
                state_nxt = st_write;
            end
        end
        st_write: begin
            if (w_beat && cnt == 8'd0) begin
                state_nxt = st_resp;
            end
        end
        st_resp: begin
            if (b_ready) begin
                state_nxt = st_idle;
            end
        end
        default: begin
            if (r_beat && cnt == 8'd0) begin
                state_nxt = st_idle;
            end
        end
    endcase
end

always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
        id_q       <= '0;
        cnt        <= 8'd0;
        issue_left <= 9'd0;
    end
    else begin
        if (req_take) begin
            id_q       <= req_sel.id;
            cnt        <= req_sel.len;
            issue_left <= {1'b0, req_sel.len} + 9'd1;
        end
        else begin
            if (w_beat | r_beat) begin
                cnt <= cnt - 8'd1;
            end
            if (rd_issue) begin
                issue_left <= issue_left - 9'd1;
            end
        end
    end
end

always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
        rd_pend    <= 1'b0;
        hold_valid <= 1'b0;
    end
    else begin
        rd_pend <= rd_issue;
        if (rd_pend && !r_ready) begin
            hold_valid <= 1'b1;
        end
        else if (r_ready) begin
            hold_valid <= 1'b0;
        end
    end
end

// Catches the word when the master stalls on a fresh beat.
always_ff @(posedge aclk) begin
    if (rd_pend && !r_ready) begin
        hold_q <= mem_rdata;
    end
end

assign mem_req.cs      = w_beat | rd_issue;
assign mem_req.we      = (state == st_write);
assign mem_req.addr    = mem_addr;
assign mem_req.byte_en = w.strb;
assign mem_req.wdata   = w.data;

assign b.id   = id_q;
assign b.resp = axi_mem_pkg::resp_okay;

assign r.id   = id_q;
assign r.data = hold_valid ? hold_q : mem_rdata;
assign r.resp = axi_mem_pkg::resp_okay;
assign r.last = (cnt == 8'd0);

endmodule

// File: src/sram_busy_mem.sv
`timescale 1ns/1ns

module sram_busy_mem (
    input  logic                             aclk,
    input  logic                             aresetn,
    input  axi_mem_pkg::mem_req_t            req,
    output logic [axi_mem_pkg::data_w-1:0]   rdata,
    output logic                             busy
);

logic [axi_mem_pkg::data_w-1:0]    mem [axi_mem_pkg::mem_words];
logic [axi_mem_pkg::refresh_w-1:0] ref_cnt;
logic [axi_mem_pkg::mem_aw-1:0]    word_idx;
logic                              take;

assign word_idx = req.addr[axi_mem_pkg::mem_aw+1:2];
assign busy     = (ref_cnt == axi_mem_pkg::refresh_last);
assign take     = req.cs & ~busy; // Requests during refresh are dropped.

// Free-running refresh timer, one busy cycle per period.
always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
        ref_cnt <= '0;
    end
    else begin
        if (busy) begin
            ref_cnt <= '0;
        end
        else begin
            ref_cnt <= ref_cnt + 1'b1;
        end
    end
end

always_ff @(posedge aclk) begin
    if (take && req.we) begin
        for (int i = 0; i < axi_mem_pkg::strb_w; i++) begin
            if (req.byte_en[i]) begin
                mem[word_idx][8*i +: 8] <= req.wdata[8*i +: 8];
            end
        end
    end
end

// The read word stays on rdata until the next accepted read.
always_ff @(posedge aclk) begin
    if (take && !req.we) begin
        rdata <= mem[word_idx];
    end
end

endmodule

// File: src/axi_mem_top.sv
`timescale 1ns/1ns

module axi_mem_top (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  axi_mem_pkg::axi_ax_t   aw,
    input  logic                   aw_valid,
    output logic                   aw_ready,
    input  axi_mem_pkg::axi_w_t    w,
    input  logic                   w_valid,
    output logic                   w_ready,
    output axi_mem_pkg::axi_b_t    b,
    output logic                   b_valid,
    input  logic                   b_ready,
    input  axi_mem_pkg::axi_ax_t   ar,
    input  logic                   ar_valid,
    output logic                   ar_ready,
    output axi_mem_pkg::axi_r_t    r,
    output logic                   r_valid,
    input  logic                   r_ready
);

axi_mem_pkg::mem_req_t           mem_req;
logic [axi_mem_pkg::data_w-1:0]  mem_rdata;
logic                            mem_busy;

axi2mem_bridge bridge0 (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .aw        (aw),
    .aw_valid  (aw_valid),
    .aw_ready  (aw_ready),
    .w         (w),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .b         (b),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .ar        (ar),
    .ar_valid  (ar_valid),
    .ar_ready  (ar_ready),
    .r         (r),
    .r_valid   (r_valid),
    .r_ready   (r_ready),
    .mem_req   (mem_req),
    .mem_rdata (mem_rdata),
    .mem_busy  (mem_busy)
);

sram_busy_mem mem0 (
    .aclk    (aclk),
    .aresetn (aresetn),
    .req     (mem_req),
    .rdata   (mem_rdata),
    .busy    (mem_busy)
);

endmodule

// File: verification/axi_mem_assert.sv
`timescale 1ns/1ns

module axi_mem_assert (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  axi_mem_pkg::axi_r_t     r,
    input  logic                    r_valid,
    input  logic                    r_ready,
    input  logic                    b_valid,
    input  logic                    b_ready,
    input  axi_mem_pkg::mem_req_t   mem_req,
    input  logic                    rd_pend
);

int unsigned fails = 0;

r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    r_valid && !r_ready |=> r_valid && $stable(r))
    else begin
        fails++;
        $error("R beat dropped or changed before r_ready.");
    end

b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    b_valid && !b_ready |=> b_valid)
    else begin
        fails++;
        $error("B response dropped before b_ready.");
    end

// A write strobe must never overlap a read that the memory is still returning.
no_wr_in_rd: assert property (@(posedge aclk) disable iff (!aresetn)
    !(mem_req.cs && mem_req.we && rd_pend))
    else begin
        fails++;
        $error("Memory write issued while a read was in flight.");
    end

endmodule

bind axi2mem_bridge axi_mem_assert assert0 (
    .aclk    (aclk),
    .aresetn (aresetn),
    .r       (r),
    .r_valid (r_valid),
    .r_ready (r_ready),
    .b_valid (b_valid),
    .b_ready (b_ready),
    .mem_req (mem_req),
    .rd_pend (rd_pend)
);

// File: verification/axi_mem_tb.sv
`timescale 1ns/1ns

module axi_mem_tb;

typedef logic [31:0] word_q_t [$];
typedef logic [3:0]  strb_q_t [$];

logic                 aclk;
logic                 aresetn;
axi_mem_pkg::axi_ax_t aw;
logic                 aw_valid;
logic                 aw_ready;
axi_mem_pkg::axi_w_t  w;
logic                 w_valid;
logic                 w_ready;
axi_mem_pkg::axi_b_t  b;
logic                 b_valid;
logic                 b_ready;
axi_mem_pkg::axi_ax_t ar;
logic                 ar_valid;
logic                 ar_ready;
axi_mem_pkg::axi_r_t  r;
logic                 r_valid;
logic                 r_ready;

logic [7:0] model [int]; // Reference memory, one entry per written byte.
int         errors;
int         checks;
int         cycles;
time        r_done_time;
time        b_time;

axi_mem_top dut0 (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready)
);

initial begin
    aclk = 1'b0;
    forever begin
        #5 aclk = ~aclk;
    end
end

// The tests need a few hundred cycles even with heavy stalls, so 4000 is a wide margin.
initial begin
    cycles = 0;
    while (cycles < 4000) begin
        @(posedge aclk);
        cycles++;
    end
    $display("Timeout, the tests did not finish within %0d cycles.", cycles);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("TEST FAILED");
    $finish;
end

// Inputs change 1 ns after the edge; outputs are sampled at the falling edge.
task automatic tick();
    @(posedge aclk);
    #1;
endtask

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
        errors++;
        $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

// Address of the following beat, from the AXI burst rules.
function automatic logic [31:0] next_addr(input logic [31:0] a, input logic [7:0] len,
                                          input logic [2:0] size, input logic [1:0] burst);
    logic [31:0] bytes;
    logic [31:0] total;
    logic [31:0] base;
    bytes = 32'd1 << size;
    total = (32'(len) + 32'd1) * bytes;
    base  = a - (a % total); // Aligned start of the wrap block.
    case (burst)
        axi_mem_pkg::burst_fixed: return a;
        axi_mem_pkg::burst_wrap:  return base + ((a - base + bytes) % total);
        default:                  return a + bytes;
    endcase
endfunction

task automatic model_write(input logic [31:0] a, input logic [31:0] data, input logic [3:0] strb);
    for (int i = 0; i < 4; i++) begin
        if (strb[i]) begin
            model[int'({a[31:2], 2'b00}) + i] = data[8*i +: 8];
        end
    end
endtask

function automatic logic [31:0] model_word(input logic [31:0] a);
    logic [31:0] word;
    for (int i = 0; i < 4; i++) begin
        if (model.exists(int'({a[31:2], 2'b00}) + i)) begin
            word[8*i +: 8] = model[int'({a[31:2], 2'b00}) + i];
        end
        else begin
            word[8*i +: 8] = 8'hxx;
        end
    end
    return word;
endfunction

function automatic word_q_t random_words(input int n);
    word_q_t q;
    for (int i = 0; i < n; i++) begin
        q.push_back($urandom);
    end
    return q;
endfunction

function automatic strb_q_t full_strobes(input int n);
    strb_q_t q;
    for (int i = 0; i < n; i++) begin
        q.push_back(4'hf);
    end
    return q;
endfunction

task automatic axi_write(input logic [10:0] id, input logic [31:0] addr, input logic [7:0] len,
                         input logic [2:0] size, input logic [1:0] burst,
                         input word_q_t data_q, input strb_q_t strb_q);
    logic [31:0] a;
    logic        done;
    a = addr;
    aw = '{id: id, addr: addr, len: len, size: size, burst: burst};
    aw_valid = 1'b1;
    done = 1'b0;
    while (!done) begin
        @(negedge aclk);
        done = aw_ready;
        tick();
    end
    aw_valid = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
        w = '{data: data_q[i], strb: strb_q[i], last: (i == int'(len))};
        w_valid = 1'b1;
        done = 1'b0;
        while (!done) begin
            @(negedge aclk);
            done = w_ready;
            tick();
        end
        model_write(a, data_q[i], strb_q[i]);
        a = next_addr(a, len, size, burst);
    end
    w_valid = 1'b0;
    b_ready = 1'b1;
    done = 1'b0;
    while (!done) begin
        @(negedge aclk);
        done = b_valid;
        if (done) begin
            check_value("b.id", 32'(b.id), 32'(id));
            check_value("b.resp", 32'(b.resp), 32'(axi_mem_pkg::resp_okay));
            b_time = $time;
        end
        tick();
    end
    b_ready = 1'b0;
endtask

// The stall percentage sets how often r_ready is held low in a cycle.
task automatic axi_read(input logic [10:0] id, input logic [31:0] addr, input logic [7:0] len,
                        input logic [2:0] size, input logic [1:0] burst, input int stall_pct);
    logic [31:0] a;
    logic        done;
    int          beat;
    a = addr;
    beat = 0;
    ar = '{id: id, addr: addr, len: len, size: size, burst: burst};
    ar_valid = 1'b1;
    done = 1'b0;
    while (!done) begin
        @(negedge aclk);
        done = ar_ready;
        tick();
    end
    ar_valid = 1'b0;
    while (beat <= int'(len)) begin
        r_ready = int'($urandom % 100) >= stall_pct;
        @(negedge aclk);
        if (r_valid && r_ready) begin
            check_value("r.data", r.data, model_word(a));
            check_value("r.id", 32'(r.id), 32'(id));
            check_value("r.resp", 32'(r.resp), 32'(axi_mem_pkg::resp_okay));
            check_value("r.last", 32'(r.last), 32'(beat == int'(len)));
            a = next_addr(a, len, size, burst);
            beat++;
            r_done_time = $time;
        end
        tick();
    end
    r_ready = 1'b0;
    @(negedge aclk);
    checks++;
    assert (!r_valid) else begin
        errors++;
        $display("Read channel showed an extra beat after the last one at %0t.", $time);
    end
    tick();
endtask

task automatic test_single();
    axi_write(11'h12a, 32'h40, 8'd0, 3'd2, axi_mem_pkg::burst_incr, random_words(1),
              full_strobes(1));
    axi_read(11'h055, 32'h40, 8'd0, 3'd2, axi_mem_pkg::burst_incr, 0);
endtask

task automatic test_incr();
    axi_write(11'h101, 32'h100, 8'd3, 3'd2, axi_mem_pkg::burst_incr, random_words(4),
              full_strobes(4));
    axi_write(11'h102, 32'h180, 8'd7, 3'd2, axi_mem_pkg::burst_incr, random_words(8),
              full_strobes(8));
    axi_read(11'h103, 32'h100, 8'd3, 3'd2, axi_mem_pkg::burst_incr, 0);
    axi_read(11'h104, 32'h180, 8'd7, 3'd2, axi_mem_pkg::burst_incr, 0);
endtask

task automatic test_wrap();
    axi_write(11'h201, 32'h308, 8'd3, 3'd2, axi_mem_pkg::burst_wrap, random_words(4),
              full_strobes(4));
    axi_read(11'h202, 32'h308, 8'd3, 3'd2, axi_mem_pkg::burst_wrap, 0);
    axi_read(11'h203, 32'h300, 8'd3, 3'd2, axi_mem_pkg::burst_incr, 0); // Linear view of the block.
endtask

task automatic test_fixed();
    strb_q_t s;
    s.push_back(4'b0101);
    axi_write(11'h301, 32'h400, 8'd2, 3'd2, axi_mem_pkg::burst_fixed, random_words(3),
              full_strobes(3));
    axi_read(11'h302, 32'h400, 8'd0, 3'd2, axi_mem_pkg::burst_incr, 0);
    axi_write(11'h303, 32'h400, 8'd0, 3'd2, axi_mem_pkg::burst_incr, random_words(1), s);
    axi_read(11'h304, 32'h400, 8'd0, 3'd2, axi_mem_pkg::burst_incr, 0);
endtask

task automatic test_stall();
    axi_write(11'h401, 32'h500, 8'd15, 3'd2, axi_mem_pkg::burst_incr, random_words(16),
              full_strobes(16));
    axi_read(11'h402, 32'h500, 8'd15, 3'd2, axi_mem_pkg::burst_incr, 50);
    axi_read(11'h403, 32'h518, 8'd7, 3'd2, axi_mem_pkg::burst_wrap, 70);
endtask

// Both requests rise together, so the read returns the old words.
task automatic test_priority();
    axi_write(11'h501, 32'h600, 8'd1, 3'd2, axi_mem_pkg::burst_incr, random_words(2),
              full_strobes(2));
    fork
        axi_read(11'h502, 32'h600, 8'd1, 3'd2, axi_mem_pkg::burst_incr, 0);
        axi_write(11'h503, 32'h600, 8'd1, 3'd2, axi_mem_pkg::burst_incr, random_words(2),
                  full_strobes(2));
    join
    checks++;
    assert (b_time > r_done_time) else begin
        errors++;
        $display("The write response came before the read burst ended at %0t.", $time);
    end
    axi_read(11'h504, 32'h600, 8'd1, 3'd2, axi_mem_pkg::burst_incr, 0);
endtask

initial begin
    void'($urandom(32'h98c7_59db));
    errors = 0;
    checks = 0;
    r_done_time = 0;
    b_time = 0;
    aresetn = 1'b0;
    aw = '0;
    aw_valid = 1'b0;
    w = '0;
    w_valid = 1'b0;
    b_ready = 1'b0;
    ar = '0;
    ar_valid = 1'b0;
    r_ready = 1'b0;
    repeat (4) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    tick();
    test_single();
    test_incr();
    test_wrap();
    test_fixed();
    test_stall();
    test_priority();
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             dut0.bridge0.assert0.fails);
    if (errors == 0 && dut0.bridge0.assert0.fails == 0) begin
        $display("TEST PASSED");
    end
    else begin
        $display("TEST FAILED");
    end
    $finish;
end

endmodule

// File: axi_mem.f
src/axi_mem_pkg.sv
src/axi_burst_addr.sv
src/axi2mem_bridge.sv
src/sram_busy_mem.sv
src/axi_mem_top.sv
verification/axi_mem_assert.sv
verification/axi_mem_tb.sv
